// ==== Makefile ====
# Verilator build and run of the CPU subsystem testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= cpu_top_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== build.f ====
+incdir+common
common/cpu_pkg.sv
common/mem_bus_if.sv
core/core_regfile.sv
core/core_exec.sv
core/core_fsm.sv
hw/clint_timer.sv
hw/bus_xbar.sv
hw/cpu_top.sv
dv/cpu_top_tb.sv

// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and address width.
`define CPU_XLEN 32

// First fetch address after reset.
`define CPU_RESET_PC 32'h8000_0000

`define CPU_NREGS 32

// Timer window, 64 KiB starting at the base.
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hffff_0000

// Offsets of the two mtime halves inside the window.
`define CLINT_MTIME_LO 16'hbff8
`define CLINT_MTIME_HI 16'hbffc

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

  // Major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_e;

  // Everything the sequencer needs from one decoded instruction.
  typedef struct packed {
    logic                 is_load;
    logic                 is_store;
    logic                 rd_wen;
    logic                 branch_taken;
    logic                 halt;
    logic                 illegal;
    logic [4:0]           rd;
    logic [`CPU_XLEN-1:0] result;
    logic [`CPU_XLEN-1:0] store_data;
    logic [`CPU_XLEN-1:0] next_pc;
  } exec_ctrl_t;

endpackage

// ==== common/mem_bus_if.sv ====
`include "cpu_defs.svh"

// Single-outstanding request/response bus, no ready on the response.
interface mem_bus_if;

  logic                 req_valid;
  logic                 req_ready;
  logic [`CPU_XLEN-1:0] addr;
  logic                 wen;
  logic [`CPU_XLEN-1:0] wdata;
  logic                 rsp_valid;
  logic [`CPU_XLEN-1:0] rdata;

  modport master (
    output req_valid, addr, wen, wdata,
    input  req_ready, rsp_valid, rdata
  );

  modport slave (
    input  req_valid, addr, wen, wdata,
    output req_ready, rsp_valid, rdata
  );

endinterface

// ==== core/core_exec.sv ====
`include "cpu_defs.svh"

module core_exec (
  input  logic [`CPU_XLEN-1:0] ir,
  input  logic [`CPU_XLEN-1:0] pc,
  input  logic [`CPU_XLEN-1:0] rs1_data,
  input  logic [`CPU_XLEN-1:0] rs2_data,
  output logic [4:0]           rs1_addr,
  output logic [4:0]           rs2_addr,
  output cpu_pkg::exec_ctrl_t  ctrl
);

  import cpu_pkg::*;

  localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

  opcode_e              opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`CPU_XLEN-1:0] imm_i;
  logic [`CPU_XLEN-1:0] imm_s;
  logic [`CPU_XLEN-1:0] imm_b;
  logic [`CPU_XLEN-1:0] imm_u;
  alu_op_e              alu_op;
  logic [`CPU_XLEN-1:0] operand_b;
  logic [`CPU_XLEN-1:0] alu_out;
  logic                 legal;
  logic                 ebreak;
  logic                 is_load;
  logic                 is_store;
  logic                 rd_wen;
  logic                 is_branch;
  logic                 taken;

  assign opcode   = opcode_e'(ir[6:0]);
  assign funct3   = ir[14:12];
  assign funct7   = ir[31:25];
  assign rs1_addr = ir[19:15];
  assign rs2_addr = ir[24:20];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};

  always_comb begin
    legal     = 1'b0;
    ebreak    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    rd_wen    = 1'b0;
    is_branch = 1'b0;
    alu_op    = ALU_ADD;
    operand_b = rs2_data;
    case (opcode)
      OPC_LUI: begin
        legal     = 1'b1;
        rd_wen    = 1'b1;
        alu_op    = ALU_PASS_B;
        operand_b = imm_u;
      end
      OPC_OP_IMM: begin
        legal     = (funct3 == 3'b000);
        rd_wen    = legal;
        operand_b = imm_i;
      end
      OPC_OP: begin
        legal  = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
        rd_wen = legal;
        alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
      end
      OPC_LOAD: begin
        legal     = (funct3 == 3'b010);
        is_load   = legal;
        rd_wen    = legal;
        operand_b = imm_i;
      end
      OPC_STORE: begin
        legal     = (funct3 == 3'b010);
        is_store  = legal;
        operand_b = imm_s;
      end
      OPC_BRANCH: begin
        // BNE only.
        legal     = (funct3 == 3'b001);
        is_branch = legal;
      end
      OPC_SYSTEM: begin
        legal  = (ir == EBREAK_INSN);
        ebreak = legal;
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = rs1_data + operand_b;
      ALU_SUB:    alu_out = rs1_data - operand_b;
      ALU_PASS_B: alu_out = operand_b;
      default:    alu_out = operand_b;
    endcase
  end

  assign taken = is_branch && (rs1_data != rs2_data);

  always_comb begin
    ctrl.is_load      = is_load;
    ctrl.is_store     = is_store;
    ctrl.rd_wen       = rd_wen;
    ctrl.branch_taken = taken;
    ctrl.halt         = ebreak || !legal;
    ctrl.illegal      = !legal;
    ctrl.rd           = ir[11:7];
    ctrl.result       = alu_out;
    ctrl.store_data   = rs2_data;
    ctrl.next_pc      = taken ? pc + imm_b : pc + 32'd4;
  end

endmodule

// ==== core/core_fsm.sv ====
`include "cpu_defs.svh"

module core_fsm (
  input  logic                 clock,
  input  logic                 arst_n,
  input  cpu_pkg::exec_ctrl_t  ctrl,
  mem_bus_if.master            bus,
  output logic [`CPU_XLEN-1:0] ir,
  output logic [`CPU_XLEN-1:0] pc,
  output logic                 rf_wen,
  output logic [4:0]           rf_waddr,
  output logic [`CPU_XLEN-1:0] rf_wdata,
  output logic                 halted,
  output logic                 illegal
);

  import cpu_pkg::*;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_WB,
    ST_HALT
  } state_e;

  state_e               state;
  logic                 req_q;
  logic                 wait_q;
  exec_ctrl_t           ctrl_q;
  logic [`CPU_XLEN-1:0] load_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_FETCH;
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      pc      <= `CPU_RESET_PC;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        ST_FETCH, ST_MEM: begin
          if (req_q) begin
            if (bus.req_ready) begin
              req_q  <= 1'b0;
              wait_q <= 1'b1;
            end
          end else if (wait_q) begin
            if (bus.rsp_valid) begin
              wait_q <= 1'b0;
              state  <= (state == ST_FETCH) ? ST_EXEC : ST_WB;
            end
          end else begin
            // Only reached on the first fetch after reset.
            req_q <= 1'b1;
          end
        end
        ST_EXEC: begin
          if (ctrl.halt) begin
            state   <= ST_HALT;
            halted  <= 1'b1;
            illegal <= ctrl.illegal;
          end else if (ctrl.is_load || ctrl.is_store) begin
            state <= ST_MEM;
            req_q <= 1'b1;
          end else begin
            state <= ST_WB;
          end
        end
        ST_WB: begin
          pc    <= ctrl_q.next_pc;
          state <= ST_FETCH;
          req_q <= 1'b1;
        end
        default: state <= ST_HALT;
      endcase
    end
  end

  // Instruction, decode result and load data.
  always_ff @(posedge clock) begin
    if (state == ST_FETCH && wait_q && bus.rsp_valid) begin
      ir <= bus.rdata;
    end
    if (state == ST_EXEC) begin
      ctrl_q <= ctrl;
    end
    if (state == ST_MEM && wait_q && bus.rsp_valid) begin
      load_q <= bus.rdata;
    end
  end

  assign bus.req_valid = req_q;
  assign bus.addr      = (state == ST_MEM) ? ctrl_q.result : pc;
  assign bus.wen       = (state == ST_MEM) && ctrl_q.is_store;
  assign bus.wdata     = ctrl_q.store_data;

  assign rf_wen   = (state == ST_WB) && ctrl_q.rd_wen;
  assign rf_waddr = ctrl_q.rd;
  assign rf_wdata = ctrl_q.is_load ? load_q : ctrl_q.result;

  // A response must belong to a request this FSM is waiting on.
  assert property (@(posedge clock) disable iff (!arst_n)
    bus.rsp_valid |-> wait_q);

  // Request fields hold until the slave accepts.
  assert property (@(posedge clock) disable iff (!arst_n)
    bus.req_valid && !bus.req_ready |=>
      bus.req_valid && $stable(bus.addr) && $stable(bus.wen) && $stable(bus.wdata));

endmodule

// ==== core/core_regfile.sv ====
`include "cpu_defs.svh"

module core_regfile (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic [4:0]           raddr1,
  input  logic [4:0]           raddr2,
  input  logic                 wen,
  input  logic [4:0]           waddr,
  input  logic [`CPU_XLEN-1:0] wdata,
  output logic [`CPU_XLEN-1:0] rdata1,
  output logic [`CPU_XLEN-1:0] rdata2
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero.
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== dv/cpu_top_tb.sv ====
`include "cpu_defs.svh"

module cpu_top_tb;

  localparam int          NUM_TESTS    = 9;
  localparam int          MEM_WORDS    = 256;
  localparam int          MAX_CYCLES   = 400;
  localparam int          CLK_PERIOD   = 40;
  localparam int          PROG_ARITH   = 0;
  localparam int          PROG_LDST    = 1;
  localparam int          PROG_BRANCH  = 2;
  localparam int          PROG_TIMER   = 3;
  localparam int          PROG_ILLEGAL = 4;
  localparam logic [31:0] MEM_BYTES    = 32'd1024;
  localparam logic [31:0] DATA_BASE    = `CPU_RESET_PC + 32'h200;
  localparam logic [31:0] EBREAK       = 32'h0010_0073;
  localparam logic [31:0] SEED         = 32'h367c_ee09;

  typedef struct packed {
    int               prog;
    logic [31:0]      p0;
    logic [31:0]      p1;
    logic [31:0]      p2;
    logic [31:0]      preload;
    int               n_stores;
    logic [2:0][31:0] exp_val;
    logic [2:0][31:0] exp_addr;
    logic             exp_illegal;
  } test_row_t;

  logic        clock;
  logic        arst_n;
  logic        mem_req_ready;
  logic        mem_rsp_valid;
  logic [31:0] mem_rdata;
  logic        mem_req_valid;
  logic [31:0] mem_addr;
  logic        mem_wen;
  logic [31:0] mem_wdata;
  logic        halted;
  logic        illegal;

  test_row_t   tbl [NUM_TESTS];
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];
  logic [31:0] req_addr;
  logic        req_wen;
  logic [31:0] req_wdata;
  logic [31:0] loop_addr;
  logic        busy;
  int          stall_left;
  int          rsp_left;
  int          loop_fetches;
  int          errors;
  int          pass_count;
  int          fail_count;

  cpu_top dut (
    .clock(clock), .arst_n(arst_n),
    .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata),
    .mem_req_valid(mem_req_valid), .mem_addr(mem_addr),
    .mem_wen(mem_wen), .mem_wdata(mem_wdata),
    .halted(halted), .illegal(illegal)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // RV32I encodings of the instructions the programs use.
  function automatic logic [31:0] lui_insn(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] addi_insn(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw_insn(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_insn(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] rtype_insn(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                             logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] bne_insn(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic in_range(logic [31:0] addr);
    return (addr - `CPU_RESET_PC) < MEM_BYTES;
  endfunction

  function automatic logic [7:0] word_index(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `CPU_RESET_PC;
    return offset[9:2];
  endfunction

  task automatic put_word(int index, logic [31:0] value);
    mem[index[7:0]] = value;
  endtask

  task automatic set_row(int idx, int prog, logic [31:0] p0, logic [31:0] p1, logic [31:0] p2,
                         logic [31:0] preload, int n, logic [31:0] v0, logic [31:0] v1,
                         logic [31:0] v2, logic [31:0] a0, logic exp_ill);
    test_row_t row;
    row.prog        = prog;
    row.p0          = p0;
    row.p1          = p1;
    row.p2          = p2;
    row.preload     = preload;
    row.n_stores    = n;
    row.exp_val     = {v2, v1, v0};
    row.exp_addr    = {a0 + 32'd8, a0 + 32'd4, a0};
    row.exp_illegal = exp_ill;
    tbl[idx[3:0]]   = row;
  endtask

  task automatic build_table();
    logic [31:0] x2;
    logic [31:0] x3;
    x2 = {20'h12345, 12'h000} + sext12(12'h678);
    x3 = sext12(12'h0ff);
    set_row(0, PROG_ARITH, 32'h12345, 32'h678, 32'h0ff, 32'h0, 3, x2 + x3, x2 - x3, 32'h0,
            DATA_BASE, 1'b0);
    x2 = {20'hfedcb, 12'h000} + sext12(12'hf38);
    x3 = sext12(12'h800);
    set_row(1, PROG_ARITH, 32'hfedcb, 32'hf38, 32'h800, 32'h0, 3, x2 + x3, x2 - x3, 32'h0,
            DATA_BASE, 1'b0);
    set_row(2, PROG_LDST, 32'h010, 32'h123, 32'h020, 32'h1234_5678, 1,
            32'h1234_5678 + sext12(12'h123), 32'h0, 32'h0, DATA_BASE + 32'h020, 1'b0);
    set_row(3, PROG_LDST, 32'h000, 32'hfff, 32'h03c, 32'h8765_4321, 1,
            32'h8765_4321 + sext12(12'hfff), 32'h0, 32'h0, DATA_BASE + 32'h03c, 1'b0);
    set_row(4, PROG_BRANCH, 32'd5, 32'h0, 32'h0, 32'h0, 1, 32'd5, 32'h0, 32'h0, DATA_BASE, 1'b0);
    set_row(5, PROG_BRANCH, 32'd1, 32'h0, 32'h0, 32'h0, 1, 32'd1, 32'h0, 32'h0, DATA_BASE, 1'b0);
    // Only the high timer word has a fixed value.
    set_row(6, PROG_TIMER, 32'h0, 32'h0, 32'h0, 32'h0, 3, 32'h0, 32'h0, 32'h0, DATA_BASE, 1'b0);
    set_row(7, PROG_ILLEGAL, 32'h02a, rtype_insn(7'h01, 5'd1, 5'd1, 5'd2), 32'h0, 32'h0, 1,
            sext12(12'h02a), 32'h0, 32'h0, DATA_BASE, 1'b1);
    set_row(8, PROG_ILLEGAL, 32'h7ff, 32'hffff_ffff, 32'h0, 32'h0, 1,
            sext12(12'h7ff), 32'h0, 32'h0, DATA_BASE, 1'b1);
  endtask

  task automatic load_memory(test_row_t row);
    for (int i = 0; i < MEM_WORDS; i++) begin
      put_word(i, fill_word(`CPU_RESET_PC + {i[29:0], 2'b00}));
    end
    // x1 holds the data base in every program.
    put_word(0, lui_insn(5'd1, 20'h80000));
    put_word(1, addi_insn(5'd1, 5'd1, 12'h200));
    loop_addr = '0;
    case (row.prog)
      PROG_ARITH: begin
        put_word(2, lui_insn(5'd2, row.p0[19:0]));
        put_word(3, addi_insn(5'd2, 5'd2, row.p1[11:0]));
        put_word(4, addi_insn(5'd3, 5'd0, row.p2[11:0]));
        put_word(5, rtype_insn(7'h00, 5'd4, 5'd2, 5'd3));
        put_word(6, rtype_insn(7'h20, 5'd5, 5'd2, 5'd3));
        put_word(7, addi_insn(5'd0, 5'd0, 12'h005));
        put_word(8, sw_insn(5'd4, 5'd1, 12'h000));
        put_word(9, sw_insn(5'd5, 5'd1, 12'h004));
        put_word(10, sw_insn(5'd0, 5'd1, 12'h008));
        put_word(11, EBREAK);
      end
      PROG_LDST: begin
        put_word(2, lw_insn(5'd2, 5'd1, row.p0[11:0]));
        put_word(3, addi_insn(5'd3, 5'd2, row.p1[11:0]));
        put_word(4, sw_insn(5'd3, 5'd1, row.p2[11:0]));
        put_word(5, EBREAK);
        mem[word_index(DATA_BASE + row.p0)] = row.preload;
      end
      PROG_BRANCH: begin
        put_word(2, addi_insn(5'd2, 5'd0, row.p0[11:0]));
        put_word(3, addi_insn(5'd3, 5'd0, 12'h000));
        put_word(4, addi_insn(5'd3, 5'd3, 12'h001));
        put_word(5, addi_insn(5'd2, 5'd2, 12'hfff));
        put_word(6, bne_insn(5'd2, 5'd0, 13'h1ff8));
        put_word(7, sw_insn(5'd3, 5'd1, 12'h000));
        put_word(8, EBREAK);
        loop_addr = `CPU_RESET_PC + 32'h10;
      end
      PROG_TIMER: begin
        // x5 sits 8 bytes above the MTIME_LO address.
        put_word(2, lui_insn(5'd5, 20'h0200c));
        put_word(3, lw_insn(5'd2, 5'd5, 12'hff8));
        put_word(4, lw_insn(5'd3, 5'd5, 12'hff8));
        put_word(5, lw_insn(5'd4, 5'd5, 12'hffc));
        put_word(6, sw_insn(5'd2, 5'd1, 12'h000));
        put_word(7, sw_insn(5'd3, 5'd1, 12'h004));
        put_word(8, sw_insn(5'd4, 5'd1, 12'h008));
        put_word(9, EBREAK);
      end
      default: begin
        put_word(2, addi_insn(5'd2, 5'd0, row.p0[11:0]));
        put_word(3, sw_insn(5'd2, 5'd1, 12'h000));
        put_word(4, row.p1);
        put_word(5, EBREAK);
      end
    endcase
  endtask

  task automatic accept_request();
    mem_req_ready <= 1'b1;
    req_addr  = mem_addr;
    req_wen   = mem_wen;
    req_wdata = mem_wdata;
    rsp_left  = $urandom_range(4, 1);
    busy      = 1'b1;
    if ((mem_addr & `CLINT_MASK) == `CLINT_BASE) begin
      $display("Error at %0t: timer address %h reached the external port", $time, mem_addr);
      errors++;
    end
    if (halted) begin
      $display("Error at %0t: external request to %h after halt", $time, mem_addr);
      errors++;
    end
    if (!in_range(mem_addr)) begin
      $display("Error at %0t: access to %h outside the memory model", $time, mem_addr);
      errors++;
    end
  endtask

  task automatic serve_request();
    if (req_wen) begin
      st_addr.push_back(req_addr);
      st_data.push_back(req_wdata);
      if (in_range(req_addr)) begin
        mem[word_index(req_addr)] = req_wdata;
      end
      mem_rdata <= '0;
    end else begin
      if (req_addr == loop_addr) begin
        loop_fetches++;
      end
      mem_rdata <= in_range(req_addr) ? mem[word_index(req_addr)] : fill_word(req_addr);
    end
    mem_rsp_valid <= 1'b1;
    stall_left = $urandom_range(3, 0);
  endtask

  // External memory with random accept stall and response delay.
  initial begin
    void'($urandom(SEED));
    busy       = 1'b0;
    rsp_left   = 0;
    stall_left = $urandom_range(3, 0);
    forever begin
      @(negedge clock);
      mem_req_ready <= 1'b0;
      mem_rsp_valid <= 1'b0;
      if (!arst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        if (rsp_left == 1) begin
          serve_request();
          busy = 1'b0;
        end else begin
          rsp_left--;
        end
      end else if (mem_req_valid) begin
        if (stall_left == 0) begin
          accept_request();
        end else begin
          stall_left--;
        end
      end
    end
  end

  task automatic check_results(int t, test_row_t row);
    if (st_data.size() != row.n_stores) begin
      $display("Mismatch at %0t: test %0d made %0d stores, expected %0d",
               $time, t, st_data.size(), row.n_stores);
      errors++;
    end else begin
      for (int k = 0; k < row.n_stores; k++) begin
        if (st_addr[k] != row.exp_addr[k[1:0]]) begin
          $display("Mismatch at %0t: test %0d store %0d address %h, expected %h",
                   $time, t, k, st_addr[k], row.exp_addr[k[1:0]]);
          errors++;
        end
        if ((row.prog != PROG_TIMER || k == 2) && st_data[k] != row.exp_val[k[1:0]]) begin
          $display("Mismatch at %0t: test %0d store %0d data %h, expected %h",
                   $time, t, k, st_data[k], row.exp_val[k[1:0]]);
          errors++;
        end
      end
      if (row.prog == PROG_TIMER && !(st_data[1] > st_data[0])) begin
        $display("Mismatch at %0t: test %0d mtime did not advance, %h then %h",
                 $time, t, st_data[0], st_data[1]);
        errors++;
      end
    end
    if (row.prog == PROG_BRANCH && loop_fetches != row.p0) begin
      $display("Mismatch at %0t: test %0d loop fetched %0d times, expected %0d",
               $time, t, loop_fetches, row.p0);
      errors++;
    end
    if (halted !== 1'b1) begin
      $display("Mismatch at %0t: test %0d halted dropped after halt", $time, t);
      errors++;
    end
    if (illegal !== row.exp_illegal) begin
      $display("Mismatch at %0t: test %0d illegal is %b, expected %b",
               $time, t, illegal, row.exp_illegal);
      errors++;
    end
  endtask

  task automatic run_test(int t);
    test_row_t row;
    row = tbl[t[3:0]];
    @(negedge clock);
    arst_n <= 1'b0;
    errors       = 0;
    loop_fetches = 0;
    st_addr.delete();
    st_data.delete();
    load_memory(row);
    repeat (10) @(negedge clock);
    arst_n <= 1'b1;
    while (halted !== 1'b1) begin
      @(negedge clock);
    end
    // Quiet period in which no external request may appear.
    repeat (20) @(negedge clock);
    check_results(t, row);
    if (errors == 0) begin
      pass_count++;
      $display("Test %0d program %0d: pass", t, row.prog);
    end else begin
      fail_count++;
      $display("Test %0d program %0d: fail with %0d errors", t, row.prog, errors);
    end
  endtask

  initial begin
    clock         = 1'b0;
    arst_n        = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    pass_count    = 0;
    fail_count    = 0;
    errors        = 0;
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * MAX_CYCLES * CLK_PERIOD);
    $display("Timeout at %0t: the core never halted", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== hw/bus_xbar.sv ====
`include "cpu_defs.svh"

module bus_xbar (
  input  logic                 clock,
  input  logic                 arst_n,
  mem_bus_if.slave             up,
  mem_bus_if.master            clint,
  input  logic                 ext_req_ready,
  input  logic                 ext_rsp_valid,
  input  logic [`CPU_XLEN-1:0] ext_rdata,
  output logic                 ext_req_valid,
  output logic [`CPU_XLEN-1:0] ext_addr,
  output logic                 ext_wen,
  output logic [`CPU_XLEN-1:0] ext_wdata
);

  logic sel_clint;
  logic pending_q;
  logic tgt_clint_q;

  assign sel_clint = ((up.addr & `CLINT_MASK) == `CLINT_BASE);

  assign clint.req_valid = up.req_valid && sel_clint;
  assign clint.addr      = up.addr;
  assign clint.wen       = up.wen;
  assign clint.wdata     = up.wdata;

  assign ext_req_valid = up.req_valid && !sel_clint;
  assign ext_addr      = up.addr;
  assign ext_wen       = up.wen;
  assign ext_wdata     = up.wdata;

  assign up.req_ready = sel_clint ? clint.req_ready : ext_req_ready;

  // Remember which target owes the response.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pending_q   <= 1'b0;
      tgt_clint_q <= 1'b0;
    end else if (up.req_valid && up.req_ready) begin
      pending_q   <= 1'b1;
      tgt_clint_q <= sel_clint;
    end else if (up.rsp_valid) begin
      pending_q <= 1'b0;
    end
  end

  assign up.rsp_valid = pending_q && (tgt_clint_q ? clint.rsp_valid : ext_rsp_valid);
  assign up.rdata     = tgt_clint_q ? clint.rdata : ext_rdata;

  assert property (@(posedge clock) disable iff (!arst_n)
    up.req_valid && up.req_ready |-> !pending_q);

endmodule

// ==== hw/clint_timer.sv ====
`include "cpu_defs.svh"

module clint_timer (
  input  logic     clock,
  input  logic     arst_n,
  mem_bus_if.slave bus
);

  logic [63:0]          mtime;
  logic                 rsp_q;
  logic [`CPU_XLEN-1:0] rdata_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
      rsp_q <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      rsp_q <= bus.req_valid;
    end
  end

  // Writes are acknowledged with zero data and have no effect.
  always_ff @(posedge clock) begin
    if (bus.req_valid) begin
      if (bus.wen) begin
        rdata_q <= '0;
      end else if (bus.addr[15:0] == `CLINT_MTIME_LO) begin
        rdata_q <= mtime[31:0];
      end else if (bus.addr[15:0] == `CLINT_MTIME_HI) begin
        rdata_q <= mtime[63:32];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus.req_ready = 1'b1;
  assign bus.rsp_valid = rsp_q;
  assign bus.rdata     = rdata_q;

endmodule

// ==== hw/cpu_top.sv ====
`include "cpu_defs.svh"

module cpu_top (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 mem_req_ready,
  input  logic                 mem_rsp_valid,
  input  logic [`CPU_XLEN-1:0] mem_rdata,
  output logic                 mem_req_valid,
  output logic [`CPU_XLEN-1:0] mem_addr,
  output logic                 mem_wen,
  output logic [`CPU_XLEN-1:0] mem_wdata,
  output logic                 halted,
  output logic                 illegal
);

  import cpu_pkg::*;

  exec_ctrl_t           exec_ctrl;
  logic [`CPU_XLEN-1:0] ir;
  logic [`CPU_XLEN-1:0] pc;
  logic [4:0]           rs1_addr;
  logic [4:0]           rs2_addr;
  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic                 rf_wen;
  logic [4:0]           rf_waddr;
  logic [`CPU_XLEN-1:0] rf_wdata;

  mem_bus_if core_bus ();
  mem_bus_if clint_bus ();

  core_fsm u_fsm (
    .clock(clock), .arst_n(arst_n),
    .ctrl(exec_ctrl), .bus(core_bus),
    .ir(ir), .pc(pc),
    .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
    .halted(halted), .illegal(illegal)
  );

  core_exec u_exec (
    .ir(ir), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .ctrl(exec_ctrl)
  );

  core_regfile u_regfile (
    .clock(clock), .arst_n(arst_n),
    .raddr1(rs1_addr), .raddr2(rs2_addr),
    .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata),
    .rdata1(rs1_data), .rdata2(rs2_data)
  );

  bus_xbar u_xbar (
    .clock(clock), .arst_n(arst_n),
    .up(core_bus), .clint(clint_bus),
    .ext_req_ready(mem_req_ready), .ext_rsp_valid(mem_rsp_valid),
    .ext_rdata(mem_rdata),
    .ext_req_valid(mem_req_valid), .ext_addr(mem_addr),
    .ext_wen(mem_wen), .ext_wdata(mem_wdata)
  );

  clint_timer u_clint (
    .clock(clock), .arst_n(arst_n),
    .bus(clint_bus)
  );

endmodule
